// File: filelist.f
src/file_io_pkg.sv
src/file_io_ctrl.sv
src/hex_loader.sv
src/hex_dumper.sv
src/image_mem.sv
src/file_io_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_file_io.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator; the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_file_io \
  -f filelist.f -o tb_file_io_sim && ./obj_dir/tb_file_io_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: dv/tb_file_io.sv
// drives file_io_top from a test table; tb_checker does all comparing
// default DUT parameters; one rx byte per two cycles, inputs move 1 ns after the edge
`default_nettype none

module tb_file_io;
  timeunit 1ns;
  timeprecision 1ps;
  import file_io_pkg::*;

  localparam int WORD_NIBBLES = 8;
  localparam int DEPTH        = 16;
  localparam int WW           = 4 * WORD_NIBBLES;
  localparam int N_TESTS      = 7;
  localparam int FRAME_LEN    = 5 + DEPTH * (WORD_NIBBLES + 2);  // header, rows, EOF
  localparam int WAIT_LIMIT   = 4 * FRAME_LEN;                  // cycles per done wait
  localparam int WATCHDOG_CYC = (N_TESTS + 1) * FRAME_LEN * 4;  // reset test included

  localparam int K_LOAD      = 0;
  localparam int K_DUMP      = 1;
  localparam int K_LOAD_BUSY = 2;  // load with a stray dump start

  logic          clk_sys;
  logic          rst_clk;
  byte_t         rx_data;
  logic          rx_valid;
  logic          load_start;
  logic          dump_start;
  logic          tx_full;
  byte_t         tx_data;
  logic          tx_valid;
  logic          busy;
  logic          load_done;
  logic          dump_done;
  integer        seed = 32'heb8e8174;
  logic [WW-1:0] cur_img [DEPTH];  // last image that finished loading

  // test table
  string t_name [N_TESTS];
  int    t_kind [N_TESTS];
  int    t_img  [N_TESTS];
  bit    t_junk [N_TESTS];
  bit    t_bp   [N_TESTS];
  int    n_added = 0;

  tb_clk_gen u_clk (
    .clk_sys (clk_sys),
    .rst_clk (rst_clk)
  );

  file_io_top DUT (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .rx_data_i    (rx_data),
    .rx_valid_i   (rx_valid),
    .load_start_i (load_start),
    .dump_start_i (dump_start),
    .tx_full_i    (tx_full),
    .tx_data_o    (tx_data),
    .tx_valid_o   (tx_valid),
    .busy_o       (busy),
    .load_done_o  (load_done),
    .dump_done_o  (dump_done)
  );

  tb_checker #(
    .WORD_NIBBLES (WORD_NIBBLES),
    .DEPTH        (DEPTH),
    .FILE_ID      (4'd1)
  ) chk (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .tx_data_i   (tx_data),
    .tx_valid_i  (tx_valid),
    .tx_full_i   (tx_full),
    .dump_done_i (dump_done),
    .load_done_i (load_done),
    .image_i     (cur_img)
  );

  task automatic add_test(input string name, input int kind, input int img,
                          input bit junk, input bit bp);
    t_name[n_added] = name;
    t_kind[n_added] = kind;
    t_img[n_added]  = img;
    t_junk[n_added] = junk;
    t_bp[n_added]   = bp;
    n_added++;
  endtask

  task automatic fill_table();
    //       name                   kind         image junk  bp
    add_test("load_a_clean",        K_LOAD,      0,    1'b0, 1'b0);
    add_test("dump_a",              K_DUMP,      0,    1'b0, 1'b0);
    add_test("load_c_junk",         K_LOAD,      2,    1'b1, 1'b0);
    add_test("dump_c",              K_DUMP,      0,    1'b0, 1'b0);
    add_test("dump_c_backpressure", K_DUMP,      0,    1'b0, 1'b1);
    add_test("load_b_dump_ignored", K_LOAD_BUSY, 1,    1'b0, 1'b0);
    add_test("dump_b_backpressure", K_DUMP,      0,    1'b0, 1'b1);
  endtask

  // odd multiplier spreads the whole address over every digit
  function automatic logic [WW-1:0] image_word(input int id, input int a);
    return (WW'(a + 1) * WW'(32'h9e37_79b9)) ^ (WW'(id) * WW'(32'h2545_f491));
  endfunction

  // any byte that is neither a hex digit nor SOT
  function automatic byte_t junk_byte();
    byte_t      c;
    logic [4:0] h;
    do
    begin
      c = byte_t'($random(seed));
      h = hex_to_nibble(c);
    end
    while (h[4] || c == CHR_SOT);
    return c;
  endfunction

  // ****************************************
  // stimulus tasks, all enter and leave 1 ns after an edge
  // ****************************************
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #1;
  endtask

  task automatic pulse_start(input bit is_dump);
    load_start = !is_dump;
    dump_start = is_dump;
    @(posedge clk_sys);
    #1;
    load_start = 1'b0;
    dump_start = 1'b0;
  endtask

  // gap cycle first, then one valid cycle
  task automatic send_byte(input byte_t c, input bit poke);
    @(posedge clk_sys);
    #1;
    rx_data    = c;
    rx_valid   = 1'b1;
    dump_start = poke;  // stray dump start rides along
    @(posedge clk_sys);
    #1;
    rx_valid   = 1'b0;
    dump_start = 1'b0;
  endtask

  task automatic load_image(input int id, input bit junk, input bit poke);
    logic [WW-1:0] w;
    byte_t         c;
    int            rnd;
    pulse_start(1'b0);
    chk.expect_level("busy_o after load start", busy, 1'b1);
    rnd = $random(seed);
    if (junk)
      repeat (1 + (rnd & 3)) send_byte(junk_byte(), 1'b0);  // noise before SOT
    send_byte(CHR_SOT, 1'b0);
    for (int a = 0; a < DEPTH; a++)
    begin
      w = image_word(id, a);
      for (int k = WORD_NIBBLES - 1; k >= 0; k--)
      begin
        c   = nibble_to_hex(w[4*k +: 4]);
        rnd = $random(seed);
        if (junk && c >= 8'h41)
          c = c | 8'h20;  // lower case a-f
        if (junk && rnd[1:0] == 2'b00)
          send_byte(junk_byte(), 1'b0);
        send_byte(c, poke && a == DEPTH / 2 && k == WORD_NIBBLES - 1);
      end
    end
    if (poke)
      chk.expect_level("busy_o after ignored dump start", busy, 1'b1);
  endtask

  // samples on the edge, then sets the next tx_full value
  task automatic wait_done(input bit is_dump, input bit bp, output bit seen);
    int n;
    int rnd;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT)
    begin
      @(posedge clk_sys);
      seen = is_dump ? dump_done : load_done;
      #1;
      rnd     = $random(seed);
      tx_full = bp && !seen && rnd[0];  // random sink stalls
      n++;
    end
  endtask

  task automatic run_test(input int i);
    bit ok;
    if (t_kind[i] == K_DUMP)
    begin
      chk.open_test(t_name[i], 1'b1, 1'b0);
      pulse_start(1'b1);
      chk.expect_level("busy_o after dump start", busy, 1'b1);
      wait_done(1'b1, t_bp[i], ok);
    end
    else
    begin
      chk.open_test(t_name[i], 1'b0, 1'b1);  // no tx byte allowed during a load
      load_image(t_img[i], t_junk[i], t_kind[i] == K_LOAD_BUSY);
      wait_done(1'b0, 1'b0, ok);
      if (ok)
        for (int a = 0; a < DEPTH; a++)
          cur_img[a] = image_word(t_img[i], a);
    end
    if (!ok)
      chk.note_failure("no done pulse arrived within the wait limit");
    idle_cycles(6);  // stray bytes show up here
    chk.expect_level("busy_o after done", busy, 1'b0);
    chk.close_test();
  endtask

  // ****************************************
  // main sequence and watchdog
  // ****************************************
  initial
  begin
    rx_data    = 8'h00;
    rx_valid   = 1'b0;
    load_start = 1'b0;
    dump_start = 1'b0;
    tx_full    = 1'b0;
    fill_table();
    @(negedge rst_clk);
    @(posedge clk_sys);
    #1;
    chk.open_test("after_reset", 1'b0, 1'b0);
    chk.expect_level("busy_o", busy, 1'b0);
    chk.expect_level("tx_valid_o", tx_valid, 1'b0);
    idle_cycles(8);
    chk.close_test();
    for (int i = 0; i < n_added; i++)
      run_test(i);
    chk.print_summary();
    if (chk.err_total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk_sys);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
// watches the tx stream and compares it to a frame rebuilt from image_i
// image_i must hold the last loaded image before open_test starts a dump
`default_nettype none

module tb_checker #(
  parameter int         WORD_NIBBLES = 8,
  parameter int         DEPTH        = 16,
  parameter logic [3:0] FILE_ID      = 4'd1
) (
  input logic                      clk_sys,
  input logic                      rst_clk,
  input file_io_pkg::byte_t        tx_data_i,
  input logic                      tx_valid_i,
  input logic                      tx_full_i,
  input logic                      dump_done_i,
  input logic                      load_done_i,
  input logic [4*WORD_NIBBLES-1:0] image_i [DEPTH]
);
  timeunit 1ns;
  timeprecision 1ps;
  import file_io_pkg::*;

  byte_t exp_q [$];           // bytes the DUT still owes
  string cur_name   = "none";
  bit    dump_open  = 1'b0;   // frame expected in this test
  int    test_errs  = 0;
  int    n_tests    = 0;
  int    n_failed   = 0;
  int    err_total  = 0;      // read by the top at the end
  int    done_loads = 0;      // load_done_o pulses in this test
  int    exp_loads  = 0;

  // digit table of its own, upper case only
  function automatic byte_t hex_char(input logic [3:0] n);
    string digits;
    digits = "0123456789ABCDEF";
    return byte_t'(digits[int'(n)]);
  endfunction

  task automatic note_failure(input string msg);
    $display("FAILURE %s: %s", cur_name, msg);
    test_errs++;
  endtask

  task automatic expect_level(input string what, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("ERROR %s: %s expected %b, actual %b", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  // ****************************************
  // test bracketing, called from the top
  // ****************************************
  task automatic open_test(input string name, input bit is_dump, input bit is_load);
    cur_name   = name;
    test_errs  = 0;
    dump_open  = is_dump;
    done_loads = 0;
    exp_loads  = is_load ? 1 : 0;  // one done pulse per load
    exp_q.delete();
    if (is_dump)
    begin
      exp_q.push_back(CHR_SOH);
      exp_q.push_back(hex_char(FILE_ID));  // file name
      exp_q.push_back(CHR_EOT);
      exp_q.push_back(CHR_SOT);
      for (int a = 0; a < DEPTH; a++)
      begin
        for (int k = WORD_NIBBLES - 1; k >= 0; k--)
          exp_q.push_back(hex_char(image_i[a][4*k +: 4]));  // msb digit first
        exp_q.push_back(CHR_CR);
        exp_q.push_back(CHR_LF);
      end
      exp_q.push_back(CHR_EOF);
    end
  endtask

  task automatic close_test();
    if (dump_open && exp_q.size() != 0)
      note_failure($sformatf("%0d frame bytes were never sent", exp_q.size()));
    if (done_loads != exp_loads)
    begin
      $display("ERROR %s: load_done_o pulses expected %0d, actual %0d", cur_name,
               exp_loads, done_loads);
      test_errs++;
    end
    dump_open = 1'b0;
    n_tests++;
    if (test_errs != 0)
      n_failed++;
    err_total += test_errs;
    $display("test %s: %s, %0d errors", cur_name, (test_errs == 0) ? "pass" : "fail",
             test_errs);
  endtask

  task automatic print_summary();
    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, err_total);
  endtask

  // ****************************************
  // tx monitor
  // ****************************************
  always @(posedge clk_sys)
  begin : tx_mon
    byte_t exp_b;
    if (!rst_clk)
    begin
      if (load_done_i)
        done_loads++;
      if (tx_valid_i && tx_full_i)
        note_failure("byte sent while tx_full_i was high");
      if (tx_valid_i)
      begin
        if (!dump_open || exp_q.size() == 0)
          note_failure($sformatf("unexpected byte %h on the tx stream", tx_data_i));
        else
        begin
          exp_b = exp_q.pop_front();
          if (tx_data_i !== exp_b)
          begin
            $display("ERROR %s: expected %h, actual %h", cur_name, exp_b, tx_data_i);
            test_errs++;
          end
          if (dump_done_i !== (exp_q.size() == 0))  // done only with EOF
            note_failure("dump_done_o not aligned with the EOF byte");
        end
      end
      else if (dump_done_i)
        note_failure("dump_done_o pulsed without a byte");
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// free-running 10 ns clock for the testbench
// reset is high over the first three rising edges, then released 1 ns after
`default_nettype none

module tb_clk_gen (
  output logic clk_sys,
  output logic rst_clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;  // 10 ns period
  end

  initial
  begin
    rst_clk = 1'b1;
    repeat (3) @(posedge clk_sys);
    #1 rst_clk = 1'b0;  // off the edge
  end

endmodule

`default_nettype wire

// File: src/file_io_top.sv
// hex loader and dumper for one memory image; byte streams are bare strobes
// rx bytes are taken each cycle rx_valid_i is high, with no flow control
`default_nettype none

module file_io_top #(
  parameter int         WORD_NIBBLES = 8,
  parameter int         DEPTH        = 16,
  parameter logic [3:0] FILE_ID      = 4'd1
) (
  input  logic               clk_sys,
  input  logic               rst_clk,
  input  file_io_pkg::byte_t rx_data_i,
  input  logic               rx_valid_i,
  input  logic               load_start_i,
  input  logic               dump_start_i,
  input  logic               tx_full_i,
  output file_io_pkg::byte_t tx_data_o,
  output logic               tx_valid_o,
  output logic               busy_o,
  output logic               load_done_o,
  output logic               dump_done_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int WW = 4 * WORD_NIBBLES;

  logic          load_go;
  logic          dump_go;
  logic          mem_we;    // loader write port
  logic [AW-1:0] mem_waddr;
  logic [WW-1:0] mem_wdata;
  logic          mem_re;    // dumper read port
  logic [AW-1:0] mem_raddr;
  logic [WW-1:0] mem_rdata;

  file_io_ctrl u_ctrl (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .load_start_i (load_start_i),
    .dump_start_i (dump_start_i),
    .load_done_i  (load_done_o),  // engine done doubles as top output
    .dump_done_i  (dump_done_o),
    .load_go_o    (load_go),
    .dump_go_o    (dump_go),
    .busy_o       (busy_o)
  );

  hex_loader #(
    .WORD_NIBBLES (WORD_NIBBLES),
    .DEPTH        (DEPTH)
  ) u_loader (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .go_i        (load_go),
    .rx_valid_i  (rx_valid_i),
    .rx_data_i   (rx_data_i),
    .mem_we_o    (mem_we),
    .mem_waddr_o (mem_waddr),
    .mem_wdata_o (mem_wdata),
    .done_o      (load_done_o)
  );

  hex_dumper #(
    .WORD_NIBBLES (WORD_NIBBLES),
    .DEPTH        (DEPTH),
    .FILE_ID      (FILE_ID)
  ) u_dumper (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .go_i        (dump_go),
    .tx_full_i   (tx_full_i),
    .mem_re_o    (mem_re),
    .mem_raddr_o (mem_raddr),
    .mem_rdata_i (mem_rdata),
    .tx_data_o   (tx_data_o),
    .tx_valid_o  (tx_valid_o),
    .done_o      (dump_done_o)
  );

  image_mem #(
    .WORD_NIBBLES (WORD_NIBBLES),
    .DEPTH        (DEPTH)
  ) u_mem (
    .clk_sys (clk_sys),
    .we_i    (mem_we),
    .waddr_i (mem_waddr),
    .wdata_i (mem_wdata),
    .re_i    (mem_re),
    .raddr_i (mem_raddr),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: src/image_mem.sv
// contents undefined until written; read data one cycle after re_i
`default_nettype none

module image_mem #(
  parameter int WORD_NIBBLES = 8,
  parameter int DEPTH        = 16
) (
  input  logic                      clk_sys,
  input  logic                      we_i,
  input  logic [$clog2(DEPTH)-1:0]  waddr_i,
  input  logic [4*WORD_NIBBLES-1:0] wdata_i,
  input  logic                      re_i,
  input  logic [$clog2(DEPTH)-1:0]  raddr_i,
  output logic [4*WORD_NIBBLES-1:0] rdata_o
);

  logic [4*WORD_NIBBLES-1:0] mem_q [DEPTH];  // storage array

  always_ff @(posedge clk_sys)
  begin
    if (we_i) mem_q[waddr_i] <= wdata_i;
    if (re_i) rdata_o <= mem_q[raddr_i];  // registered read, old data on collision
  end

endmodule

`default_nettype wire

// File: src/hex_dumper.sv
// frame is SOH, FILE_ID digit, EOT, SOT, DEPTH rows of hex + CR LF, EOF
// tx_full_i is seen in the same cycle; no byte goes out while it is high
`default_nettype none

module hex_dumper #(
  parameter int         WORD_NIBBLES = 8,
  parameter int         DEPTH        = 16,
  parameter logic [3:0] FILE_ID      = 4'd1
) (
  input  logic                      clk_sys,
  input  logic                      rst_clk,
  input  logic                      go_i,
  input  logic                      tx_full_i,
  output logic                      mem_re_o,
  output logic [$clog2(DEPTH)-1:0]  mem_raddr_o,
  input  logic [4*WORD_NIBBLES-1:0] mem_rdata_i,
  output file_io_pkg::byte_t        tx_data_o,
  output logic                      tx_valid_o,
  output logic                      done_o
);
  import file_io_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam int NW = $clog2(WORD_NIBBLES);
  localparam int WW = 4 * WORD_NIBBLES;

  dump_state_e   state_q;
  logic [1:0]    hdr_idx_q;     // SOH, id, EOT, SOT
  logic [AW-1:0] row_q;
  logic [NW-1:0] nib_idx_q;
  logic [WW-1:0] word_q;        // top nibble is the next digit
  logic          fetch_wait_q;  // read issued, data due next cycle
  logic          lf_q;          // CR already sent
  logic          emit_st;
  logic          emit;

  assign emit_st = (state_q inside {D_HEADER, D_ROW, D_EOL, D_EOF});
  assign emit    = emit_st && !tx_full_i;  // back-pressure gate

  // ****************************************
  // sequencer
  // ****************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q      <= D_IDLE;
      hdr_idx_q    <= '0;
      row_q        <= '0;
      nib_idx_q    <= '0;
      fetch_wait_q <= 1'b0;
      lf_q         <= 1'b0;
    end
    else
    begin
      case (state_q)
        D_IDLE:
        begin
          if (go_i)
          begin
            state_q   <= D_HEADER;
            hdr_idx_q <= '0;
            row_q     <= '0;
          end
        end
        D_HEADER:
        begin
          if (emit)
          begin
            hdr_idx_q <= hdr_idx_q + 1'b1;
            if (hdr_idx_q == 2'd3)
            begin
              state_q      <= D_FETCH;
              fetch_wait_q <= 1'b0;
            end
          end
        end
        D_FETCH:  // one cycle read, one cycle latency
        begin
          fetch_wait_q <= !fetch_wait_q;
          if (fetch_wait_q)
          begin
            state_q   <= D_ROW;
            nib_idx_q <= '0;
          end
        end
        D_ROW:
        begin
          if (emit)
          begin
            nib_idx_q <= nib_idx_q + 1'b1;
            if (nib_idx_q == NW'(WORD_NIBBLES - 1))
            begin
              state_q <= D_EOL;
              lf_q    <= 1'b0;
            end
          end
        end
        D_EOL:
        begin
          if (emit)
          begin
            lf_q <= 1'b1;
            if (lf_q && row_q == AW'(DEPTH - 1))
              state_q <= D_EOF;
            else if (lf_q)
            begin
              row_q        <= row_q + 1'b1;
              state_q      <= D_FETCH;
              fetch_wait_q <= 1'b0;
            end
          end
        end
        D_EOF:
        begin
          if (emit) state_q <= D_IDLE;
        end
        default: state_q <= D_IDLE;
      endcase
    end
  end

  // word register, loaded on the latency cycle, shifted per digit
  always_ff @(posedge clk_sys)
  begin
    if (state_q == D_FETCH && fetch_wait_q)
      word_q <= mem_rdata_i;
    else if (emit && state_q == D_ROW)
      word_q <= word_q << 4;
  end

  // byte mux
  always_comb
  begin
    tx_data_o = 8'h00;
    case (state_q)
      D_HEADER:
      begin
        case (hdr_idx_q)
          2'd0:    tx_data_o = CHR_SOH;
          2'd1:    tx_data_o = nibble_to_hex(FILE_ID);  // file name
          2'd2:    tx_data_o = CHR_EOT;
          default: tx_data_o = CHR_SOT;
        endcase
      end
      D_ROW:   tx_data_o = nibble_to_hex(word_q[WW-1 -: 4]);
      D_EOL:   tx_data_o = lf_q ? CHR_LF : CHR_CR;
      D_EOF:   tx_data_o = CHR_EOF;
      default: tx_data_o = 8'h00;
    endcase
  end

  assign tx_valid_o  = emit;
  assign done_o      = emit && (state_q == D_EOF);
  assign mem_re_o    = (state_q == D_FETCH) && !fetch_wait_q;
  assign mem_raddr_o = row_q;

  a_no_tx_when_full: assert property (@(posedge clk_sys) disable iff (rst_clk)
    tx_full_i |-> !tx_valid_o);
  // a stalled byte stays put until the sink frees up
  a_hold_on_full: assert property (@(posedge clk_sys) disable iff (rst_clk)
    (emit_st && tx_full_i) |=> $stable(tx_data_o) && $stable(state_q));

endmodule

`default_nettype wire

// File: src/hex_loader.sv
// needs WORD_NIBBLES >= 2 and DEPTH >= 2; exactly DEPTH words end a load
// a byte arriving in the write cycle is lost
`default_nettype none

module hex_loader #(
  parameter int WORD_NIBBLES = 8,
  parameter int DEPTH        = 16
) (
  input  logic                      clk_sys,
  input  logic                      rst_clk,
  input  logic                      go_i,
  input  logic                      rx_valid_i,
  input  file_io_pkg::byte_t        rx_data_i,
  output logic                      mem_we_o,
  output logic [$clog2(DEPTH)-1:0]  mem_waddr_o,
  output logic [4*WORD_NIBBLES-1:0] mem_wdata_o,
  output logic                      done_o
);
  import file_io_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam int NW = $clog2(WORD_NIBBLES);
  localparam int WW = 4 * WORD_NIBBLES;

  load_state_e   state_q;
  logic [NW-1:0] nib_cnt_q;  // nibbles already in word_q
  logic [AW-1:0] addr_q;     // next write address
  logic [WW-1:0] word_q;     // assembly register, msb first
  logic [4:0]    hex;
  logic          hex_ok;
  logic          last_nib;
  logic          last_word;

  assign hex       = hex_to_nibble(rx_data_i);
  assign hex_ok    = rx_valid_i && hex[4] && (state_q == L_DATA);  // junk skipped
  assign last_nib  = (nib_cnt_q == NW'(WORD_NIBBLES - 1));
  assign last_word = (addr_q == AW'(DEPTH - 1));

  // ****************************************
  // sequencer
  // ****************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q   <= L_IDLE;
      nib_cnt_q <= '0;
      addr_q    <= '0;
    end
    else
    begin
      case (state_q)
        L_IDLE:
        begin
          if (go_i) state_q <= L_WAIT_SOT;
        end
        L_WAIT_SOT:  // everything before SOT is dropped
        begin
          if (rx_valid_i && rx_data_i == CHR_SOT)
          begin
            state_q   <= L_DATA;
            nib_cnt_q <= '0;
            addr_q    <= '0;
          end
        end
        L_DATA:
        begin
          if (hex_ok)
          begin
            nib_cnt_q <= last_nib ? '0 : nib_cnt_q + 1'b1;
            if (last_nib) state_q <= L_WRITE;
          end
        end
        L_WRITE:
        begin
          addr_q  <= addr_q + 1'b1;  // wraps to 0 after the last word
          state_q <= last_word ? L_IDLE : L_DATA;
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // payload, shift in from the right
  always_ff @(posedge clk_sys)
  begin
    if (hex_ok) word_q <= {word_q[WW-5:0], hex[3:0]};
  end

  assign mem_we_o    = (state_q == L_WRITE);
  assign mem_waddr_o = addr_q;
  assign mem_wdata_o = word_q;
  assign done_o      = mem_we_o && last_word;  // write cycle of the final word

  // each write is preceded by the last nibble of its word
  a_we_after_word: assert property (@(posedge clk_sys) disable iff (rst_clk)
    mem_we_o |-> $past(hex_ok && last_nib));

endmodule

`default_nettype wire

// File: src/file_io_ctrl.sv
// start pulses are taken only in IDLE; load wins if both come together
// one engine runs at a time until its done pulse
`default_nettype none

module file_io_ctrl (
  input  logic clk_sys,
  input  logic rst_clk,
  input  logic load_start_i,
  input  logic dump_start_i,
  input  logic load_done_i,
  input  logic dump_done_i,
  output logic load_go_o,
  output logic dump_go_o,
  output logic busy_o
);
  import file_io_pkg::*;

  ctrl_state_e state_q;

  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q   <= IDLE;
      load_go_o <= 1'b0;
      dump_go_o <= 1'b0;
    end
    else
    begin
      load_go_o <= 1'b0;  // go is a single cycle
      dump_go_o <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (load_start_i)
          begin
            state_q   <= LOADING;
            load_go_o <= 1'b1;
          end
          else if (dump_start_i)
          begin
            state_q   <= DUMPING;
            dump_go_o <= 1'b1;
          end
        end
        LOADING: if (load_done_i) state_q <= IDLE;
        DUMPING: if (dump_done_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  assign busy_o = (state_q != IDLE);  // starts while busy are dropped

  // ****************************************
  // checks
  // ****************************************
  a_go_excl: assert property (@(posedge clk_sys) disable iff (rst_clk)
    !(load_go_o && dump_go_o));

endmodule

`default_nettype wire

// File: src/file_io_pkg.sv
// shared byte type, frame control bytes and FSM encodings
// hex helpers take plain ASCII; bit 7 of a character is not ignored
`default_nettype none

package file_io_pkg;

  typedef logic [7:0] byte_t;  // one stream character

  // ****************************************
  // frame control bytes
  // ****************************************
  localparam byte_t CHR_SOH = 8'h01;
  localparam byte_t CHR_SOT = 8'h02;
  localparam byte_t CHR_EOT = 8'h03;
  localparam byte_t CHR_EOF = 8'h04;
  localparam byte_t CHR_LF  = 8'h0a;
  localparam byte_t CHR_CR  = 8'h0d;

  typedef enum logic [1:0] {IDLE, LOADING, DUMPING} ctrl_state_e;
  typedef enum logic [1:0] {L_IDLE, L_WAIT_SOT, L_DATA, L_WRITE} load_state_e;
  typedef enum logic [2:0] {D_IDLE, D_HEADER, D_FETCH, D_ROW, D_EOL, D_EOF} dump_state_e;

  // bit 4 set when c is 0-9, A-F or a-f; bits 3:0 hold the value
  function automatic logic [4:0] hex_to_nibble(byte_t c);
    logic [4:0] r;
    r = 5'h00;  // invalid
    if (c >= 8'h30 && c <= 8'h39)
    begin
      r = {1'b1, c[3:0]};
    end
    else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66))
    begin
      r = {1'b1, c[3:0] + 4'd9};  // 'A' low nibble 1 -> 10
    end
    return r;
  endfunction

  // upper case digit only
  function automatic byte_t nibble_to_hex(logic [3:0] n);
    byte_t r;
    if (n < 4'd10)
      r = 8'h30 + {4'h0, n};
    else
      r = 8'h37 + {4'h0, n};  // 10 -> 'A'
    return r;
  endfunction

endpackage

`default_nettype wire
